/* include/lcd_macros.svh */
`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

// Default timing in clock cycles
`define LCD_SETTLE_CYCLES_DEF 262143
`define LCD_EN_CYCLES_DEF     16

// Frame layout
`define LCD_INIT_LEN   5
`define LCD_LINE1_IDX  5
`define LCD_CHLINE_IDX 21
`define LCD_LINE2_IDX  22
`define LCD_FRAME_LEN  38

// HD44780 commands
`define LCD_CMD_FUNC  8'h38 // 8-bit bus, 2 lines, 5x8 font
`define LCD_CMD_DISP  8'h0C // Display on, no cursor
`define LCD_CMD_CLEAR 8'h01
`define LCD_CMD_ENTRY 8'h06 // Increment, no shift
`define LCD_CMD_LINE1 8'h80
`define LCD_CMD_LINE2 8'hC0

`endif

/* hdl/text_pkg.sv */
package text_pkg;

	// One character code
	typedef logic [7:0] char_t;

	// Column on a line, 0 to 15
	typedef logic [3:0] col_t;

	// 0 is line 1, 1 is line 2
	typedef logic line_t;

endpackage : text_pkg

/* hdl/lcd_bus_pkg.sv */
package lcd_bus_pkg;

	typedef logic [7:0] lcd_byte_t;

	// Index into the 38-entry frame table
	typedef logic [5:0] frame_idx_t;

	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		SEND       = 3'd1,
		SETTLE     = 3'd2,
		NEXT_CHECK = 3'd3,
		LOAD       = 3'd4
	} seq_state_t;

	typedef enum logic [1:0] {
		W_IDLE   = 2'd0,
		W_SETUP  = 2'd1,
		W_ENABLE = 2'd2,
		W_HOLD   = 2'd3
	} wr_state_t;

endpackage : lcd_bus_pkg

/* hdl/lcd_bus_writer.sv */
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_bus_writer #(
	parameter int unsigned EN_CYCLES = `LCD_EN_CYCLES_DEF
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   start,
	input  lcd_bus_pkg::lcd_byte_t byte_data,
	input  logic                   byte_rs,
	output logic                   done,
	output lcd_bus_pkg::lcd_byte_t lcd_data,
	output logic                   lcd_rs,
	output logic                   lcd_rw,
	output logic                   lcd_en
);
	import lcd_bus_pkg::*;

	localparam int unsigned CNT_W = $clog2(EN_CYCLES + 1);

	wr_state_t        state, state_next;
	logic [CNT_W-1:0] cnt, cnt_next;
	lcd_byte_t        data_next;
	logic             rs_next;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= W_IDLE;
			cnt <= '0;
			lcd_data <= '0;
			lcd_rs <= 1'b0;
		end else begin
			state <= state_next;
			cnt <= cnt_next;
			lcd_data <= data_next;
			lcd_rs <= rs_next;
		end
	end

	always_comb begin
		state_next = state;
		cnt_next = cnt;
		data_next = lcd_data;
		rs_next = lcd_rs;

		case (state)
			W_IDLE: begin
				if (start) begin
					data_next = byte_data; // Held until the next start
					rs_next = byte_rs;
					state_next = W_SETUP;
				end
			end
			W_SETUP: begin
				cnt_next = '0;
				state_next = W_ENABLE;
			end
			W_ENABLE: begin
				if (cnt == CNT_W'(EN_CYCLES - 1))
					state_next = W_HOLD;
				else
					cnt_next = cnt + 1'b1;
			end
			W_HOLD: state_next = W_IDLE;
			default: state_next = W_IDLE;
		endcase
	end

	assign lcd_en = (state == W_ENABLE);
	assign done = (state == W_HOLD); // Seen by the sequencer at the end of hold
	assign lcd_rw = 1'b0; // Write only

	a_data_stable_en: assert property (@(posedge clk) disable iff (!rstN)
		lcd_en |-> $stable(lcd_data));

	a_done_single: assert property (@(posedge clk) disable iff (!rstN)
		done |=> !done);

endmodule : lcd_bus_writer

/* hdl/lcd_frame_sequencer.sv */
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_frame_sequencer #(
	parameter int unsigned SETTLE_CYCLES = `LCD_SETTLE_CYCLES_DEF,
	parameter int unsigned EN_CYCLES     = `LCD_EN_CYCLES_DEF
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   refresh_req,
	input  text_pkg::char_t        line_1 [0:15],
	input  text_pkg::char_t        line_2 [0:15],
	output logic                   frame_take,
	output logic                   ready,
	output lcd_bus_pkg::lcd_byte_t lcd_data,
	output logic                   lcd_rs,
	output logic                   lcd_rw,
	output logic                   lcd_en
);
	import lcd_bus_pkg::*;

	localparam int unsigned DLY_W = $clog2(SETTLE_CYCLES + 1);

	seq_state_t       state, state_next;
	frame_idx_t       idx, idx_next;
	logic [DLY_W-1:0] dly, dly_next;
	logic             start, start_next;
	lcd_byte_t        byte_data, byte_data_next;
	logic             byte_rs, byte_rs_next;
	logic             done;

	// Table entry registered from idx_next so it always matches idx
	lcd_byte_t        lut_byte;
	logic             lut_rs;
	logic [3:0]       l1_col, l2_col;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= IDLE;
			idx <= '0;
			dly <= '0;
			start <= 1'b0;
			byte_data <= '0;
			byte_rs <= 1'b0;
		end else begin
			state <= state_next;
			idx <= idx_next;
			dly <= dly_next;
			start <= start_next;
			byte_data <= byte_data_next;
			byte_rs <= byte_rs_next;
		end
	end

	always_comb begin
		state_next = state;
		idx_next = idx;
		dly_next = dly;
		start_next = start;
		byte_data_next = byte_data;
		byte_rs_next = byte_rs;

		case (state)
			IDLE: begin
				start_next = 1'b0;
				if (refresh_req) begin // Entry 0 is already in the table register
					state_next = SEND;
					start_next = 1'b1;
					byte_data_next = lut_byte;
					byte_rs_next = lut_rs;
				end
			end

			SEND: begin
				if (done) begin
					start_next = 1'b0;
					dly_next = '0;
					state_next = SETTLE;
				end
			end

			SETTLE: begin
				dly_next = dly + 1'b1;
				if (dly == DLY_W'(SETTLE_CYCLES - 1)) begin
					dly_next = '0;
					idx_next = idx + 1'b1;
					state_next = NEXT_CHECK;
				end
			end

			NEXT_CHECK: begin
				if (idx < frame_idx_t'(`LCD_FRAME_LEN)) begin
					state_next = LOAD;
				end else begin
					idx_next = '0;
					state_next = IDLE;
				end
			end

			LOAD: begin
				byte_data_next = lut_byte;
				byte_rs_next = lut_rs;
				start_next = 1'b1;
				state_next = SEND;
			end

			default: state_next = IDLE;
		endcase
	end

	assign ready = (state == IDLE);
	assign frame_take = (state == IDLE) && refresh_req;

	// Column within each text line
	assign l1_col = 4'(idx_next - frame_idx_t'(`LCD_LINE1_IDX));
	assign l2_col = 4'(idx_next - frame_idx_t'(`LCD_LINE2_IDX));

	always_ff @(posedge clk) begin
		if (idx_next < frame_idx_t'(`LCD_INIT_LEN)) begin
			lut_rs <= 1'b0;
			case (idx_next[2:0])
				3'd0: lut_byte <= `LCD_CMD_FUNC;
				3'd1: lut_byte <= `LCD_CMD_DISP;
				3'd2: lut_byte <= `LCD_CMD_CLEAR;
				3'd3: lut_byte <= `LCD_CMD_ENTRY;
				default: lut_byte <= `LCD_CMD_LINE1;
			endcase
		end else if (idx_next < frame_idx_t'(`LCD_CHLINE_IDX)) begin
			lut_rs <= 1'b1;
			lut_byte <= line_1[l1_col];
		end else if (idx_next == frame_idx_t'(`LCD_CHLINE_IDX)) begin
			lut_rs <= 1'b0;
			lut_byte <= `LCD_CMD_LINE2; // Jump to line 2
		end else begin
			lut_rs <= 1'b1;
			lut_byte <= line_2[l2_col];
		end
	end

	lcd_bus_writer #(
		.EN_CYCLES(EN_CYCLES)
	) writer_i (
		.clk      (clk),
		.rstN     (rstN),
		.start    (start),
		.byte_data(byte_data),
		.byte_rs  (byte_rs),
		.done     (done),
		.lcd_data (lcd_data),
		.lcd_rs   (lcd_rs),
		.lcd_rw   (lcd_rw),
		.lcd_en   (lcd_en)
	);

	// End of table only seen while deciding to stop
	a_idx_range: assert property (@(posedge clk) disable iff (!rstN)
		(idx == frame_idx_t'(`LCD_FRAME_LEN)) |-> (state == NEXT_CHECK));

endmodule : lcd_frame_sequencer

/* hdl/text_buffer.sv */
`timescale 1ns/1ps

module text_buffer (
	input  logic            clk,
	input  logic            rstN,
	input  logic            wr_en,
	input  text_pkg::line_t wr_line,
	input  text_pkg::col_t  wr_col,
	input  text_pkg::char_t wr_char,
	input  logic            refresh,
	input  logic            frame_take,
	output logic            refresh_req,
	output text_pkg::char_t line_1 [0:15],
	output text_pkg::char_t line_2 [0:15]
);
	import text_pkg::*;

	char_t shadow_1 [0:15];
	char_t shadow_2 [0:15];

	// Host side copy
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				shadow_1[i] <= 8'h20;
				shadow_2[i] <= 8'h20;
			end
		end else if (wr_en) begin
			if (wr_line == 1'b0)
				shadow_1[wr_col] <= wr_char;
			else
				shadow_2[wr_col] <= wr_char;
		end
	end

	// Frame copy frozen while the sequencer sends
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				line_1[i] <= 8'h20;
				line_2[i] <= 8'h20;
			end
		end else if (frame_take) begin
			line_1 <= shadow_1;
			line_2 <= shadow_2;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			refresh_req <= 1'b0;
		else if (refresh)
			refresh_req <= 1'b1; // Wins over a take in the same cycle
		else if (frame_take)
			refresh_req <= 1'b0;
	end

	a_take_on_req: assert property (@(posedge clk) disable iff (!rstN)
		frame_take |-> refresh_req);

endmodule : text_buffer

/* hdl/lcd_display_top.sv */
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_display_top #(
	parameter int unsigned SETTLE_CYCLES = `LCD_SETTLE_CYCLES_DEF,
	parameter int unsigned EN_CYCLES     = `LCD_EN_CYCLES_DEF
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   wr_en,
	input  text_pkg::line_t        wr_line,
	input  text_pkg::col_t         wr_col,
	input  text_pkg::char_t        wr_char,
	input  logic                   refresh,
	output logic                   ready,
	output lcd_bus_pkg::lcd_byte_t lcd_data,
	output logic                   lcd_rs,
	output logic                   lcd_rw,
	output logic                   lcd_en,
	output logic                   lcd_on,
	output logic                   lcd_blon
);
	import text_pkg::*;

	logic  refresh_req;
	logic  frame_take;
	char_t line_1 [0:15];
	char_t line_2 [0:15];

	assign lcd_on = 1'b1;
	assign lcd_blon = 1'b1; // Backlight always on

	text_buffer buffer_i (
		.clk        (clk),
		.rstN       (rstN),
		.wr_en      (wr_en),
		.wr_line    (wr_line),
		.wr_col     (wr_col),
		.wr_char    (wr_char),
		.refresh    (refresh),
		.frame_take (frame_take),
		.refresh_req(refresh_req),
		.line_1     (line_1),
		.line_2     (line_2)
	);

	lcd_frame_sequencer #(
		.SETTLE_CYCLES(SETTLE_CYCLES),
		.EN_CYCLES    (EN_CYCLES)
	) seq_i (
		.clk        (clk),
		.rstN       (rstN),
		.refresh_req(refresh_req),
		.line_1     (line_1),
		.line_2     (line_2),
		.frame_take (frame_take),
		.ready      (ready),
		.lcd_data   (lcd_data),
		.lcd_rs     (lcd_rs),
		.lcd_rw     (lcd_rw),
		.lcd_en     (lcd_en)
	);

endmodule : lcd_display_top

/* test/lcd_display_tb.sv */
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_display_tb;

	localparam int SETTLE_CYCLES = 20;
	localparam int EN_CYCLES = 4;
	localparam int FRAME_TIMEOUT = 3000; // About 1100 cycles per frame

	logic       clk;
	logic       rstN;
	logic       wr_en;
	logic       wr_line;
	logic [3:0] wr_col;
	logic [7:0] wr_char;
	logic       refresh;
	logic       ready;
	logic [7:0] lcd_data;
	logic       lcd_rs;
	logic       lcd_rw;
	logic       lcd_en;
	logic       lcd_on;
	logic       lcd_blon;

	logic [7:0]  tb_shadow [0:31]; // Line 1 at 0..15, line 2 at 16..31
	logic [7:0]  model_text [0:31];
	logic [8:0]  cap_q [$]; // {rs, data} per enable pulse
	int          width_q [$];
	int          gap_q [$];
	int          rw_bad = 0;
	int          err_count = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          frames_sent = 0;
	logic [31:0] lcg_state = 32'he7cb5ce6;

	logic        en_prev = 1'b0;
	logic        seen_en = 1'b0;
	int          en_width = 0;
	int          gap_cnt = 0;

	lcd_display_top #(
		.SETTLE_CYCLES(SETTLE_CYCLES),
		.EN_CYCLES    (EN_CYCLES)
	) dut_i (
		.clk     (clk),
		.rstN    (rstN),
		.wr_en   (wr_en),
		.wr_line (wr_line),
		.wr_col  (wr_col),
		.wr_char (wr_char),
		.refresh (refresh),
		.ready   (ready),
		.lcd_data(lcd_data),
		.lcd_rs  (lcd_rs),
		.lcd_rw  (lcd_rw),
		.lcd_en  (lcd_en),
		.lcd_on  (lcd_on),
		.lcd_blon(lcd_blon)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Bus monitor sampling at the falling clock edge
	always @(negedge clk) begin
		if (rstN) begin
			if (lcd_rw !== 1'b0)
				rw_bad++;
			if (lcd_en === 1'b1) begin
				if (!en_prev && seen_en)
					gap_q.push_back(gap_cnt);
				en_width++;
			end else begin
				if (en_prev) begin
					cap_q.push_back({lcd_rs, lcd_data});
					width_q.push_back(en_width);
					en_width = 0;
					gap_cnt = 0;
					seen_en = 1'b1;
				end
				gap_cnt++;
			end
			en_prev = lcd_en;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			err_count++;
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Expected {rs, byte} for one frame position
	function automatic logic [8:0] expected_entry(input int i);
		case (i)
			0: return {1'b0, `LCD_CMD_FUNC};
			1: return {1'b0, `LCD_CMD_DISP};
			2: return {1'b0, `LCD_CMD_CLEAR};
			3: return {1'b0, `LCD_CMD_ENTRY};
			4: return {1'b0, `LCD_CMD_LINE1};
			`LCD_CHLINE_IDX: return {1'b0, `LCD_CMD_LINE2};
			default: begin
				if (i < `LCD_CHLINE_IDX)
					return {1'b1, model_text[i - `LCD_LINE1_IDX]};
				return {1'b1, model_text[16 + i - `LCD_LINE2_IDX]};
			end
		endcase
	endfunction

	task automatic write_char(input logic line, input logic [3:0] col, input logic [7:0] ch);
		@(negedge clk);
		wr_en = 1'b1;
		wr_line = line;
		wr_col = col;
		wr_char = ch;
		tb_shadow[{line, col}] = ch;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic pulse_refresh();
		@(negedge clk);
		refresh = 1'b1;
		@(negedge clk);
		refresh = 1'b0;
	endtask

	task automatic wait_ready(input logic lvl, input int max_cycles, input string what);
		int cnt = 0;
		while (ready !== lvl && cnt < max_cycles) begin
			@(negedge clk);
			cnt++;
		end
		if (ready !== lvl) begin
			$display("Timeout in %s: ready did not go to %0d", what, lvl);
			err_count++;
		end
	endtask

	task automatic wait_captures(input int n, input int max_cycles, input string what);
		int cnt = 0;
		while (cap_q.size() < n && cnt < max_cycles) begin
			@(negedge clk);
			cnt++;
		end
		if (cap_q.size() < n) begin
			$display("Timeout in %s: only %0d of %0d bus writes seen", what, cap_q.size(), n);
			err_count++;
		end
	endtask

	task automatic compare_frame(input int base, input string tag);
		for (int i = 0; i < `LCD_FRAME_LEN; i++)
			check($sformatf("%s bus write %0d", tag, i), cap_q[base + i], expected_entry(i));
	endtask

	// Snapshot the shadow, refresh and check one whole frame
	task automatic send_frame(input string tag);
		cap_q.delete();
		model_text = tb_shadow;
		pulse_refresh();
		wait_captures(`LCD_FRAME_LEN, FRAME_TIMEOUT, tag);
		wait_ready(1'b1, FRAME_TIMEOUT, tag);
		check({tag, " bus write count"}, cap_q.size(), `LCD_FRAME_LEN);
		if (cap_q.size() >= `LCD_FRAME_LEN)
			compare_frame(0, tag);
		frames_sent++;
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			$display("Test %s: passed", name);
			tests_passed++;
		end else begin
			$display("Test %s: failed with %0d errors", name, err_count - errs_before);
			tests_failed++;
		end
	endtask

	task automatic test_reset();
		int e = err_count;
		check("ready", ready, 1);
		check("lcd_en", lcd_en, 0);
		check("lcd_rw", lcd_rw, 0);
		check("lcd_on", lcd_on, 1);
		check("lcd_blon", lcd_blon, 1);
		repeat (200) @(negedge clk);
		check("enable pulses without refresh", cap_q.size(), 0);
		end_test("reset state", e);
	endtask

	task automatic test_blank();
		int e = err_count;
		send_frame("blank");
		end_test("unwritten text is spaces", e);
	endtask

	task automatic test_pattern();
		int e = err_count;
		for (int p = 0; p < 32; p++)
			write_char(p[4], p[3:0], 8'h41 + p[7:0]);
		send_frame("pattern");
		end_test("full pattern frame", e);
	endtask

	task automatic test_refresh_in_frame();
		int e = err_count;
		logic [7:0] old_text [0:31];
		cap_q.delete();
		old_text = tb_shadow;
		pulse_refresh();
		wait_ready(1'b0, 50, "refresh in frame start");
		for (int c = 0; c < 16; c++)
			write_char(1'b1, c[3:0], 8'h61 + c[7:0]);
		write_char(1'b0, 4'd0, 8'h2A);
		pulse_refresh();
		repeat (10) @(negedge clk);
		pulse_refresh();
		check("ready during frame", ready, 0);
		wait_captures(2 * `LCD_FRAME_LEN, 2 * FRAME_TIMEOUT, "refresh in frame");
		wait_ready(1'b1, FRAME_TIMEOUT, "refresh in frame");
		repeat (200) @(negedge clk); // No third frame may follow
		check("bus writes after two refreshes", cap_q.size(), 2 * `LCD_FRAME_LEN);
		if (cap_q.size() >= 2 * `LCD_FRAME_LEN) begin
			model_text = old_text;
			compare_frame(0, "old frame");
			model_text = tb_shadow;
			compare_frame(`LCD_FRAME_LEN, "new frame");
		end
		frames_sent += 2;
		end_test("refresh during frame", e);
	endtask

	task automatic test_random();
		int e = err_count;
		logic [31:0] r;
		for (int p = 0; p < 32; p++) begin
			r = lcg_next();
			write_char(p[4], p[3:0], 8'h20 + 8'(r[23:16] % 95)); // Printable range
		end
		send_frame("random");
		end_test("random text frame", e);
	endtask

	task automatic test_timing();
		int e = err_count;
		check("enable pulse count", width_q.size(), frames_sent * `LCD_FRAME_LEN);
		check("cycles with lcd_rw high", rw_bad, 0);
		foreach (width_q[i])
			check($sformatf("enable width %0d", i), width_q[i], EN_CYCLES);
		foreach (gap_q[i])
			check($sformatf("enable gap %0d long enough", i), gap_q[i] >= SETTLE_CYCLES, 1);
		end_test("bus timing", e);
	endtask

	initial begin
		rstN = 1'b0;
		wr_en = 1'b0;
		wr_line = 1'b0;
		wr_col = 4'd0;
		wr_char = 8'h00;
		refresh = 1'b0;
		for (int p = 0; p < 32; p++)
			tb_shadow[p] = 8'h20;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		test_reset();
		test_blank();
		test_pattern();
		test_refresh_in_frame();
		test_random();
		test_timing();

		$display("Tests passed %0d, failed %0d, check errors %0d",
			tests_passed, tests_failed, err_count);
		if (err_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule : lcd_display_tb

/* all.f */
+incdir+include
hdl/text_pkg.sv
hdl/lcd_bus_pkg.sv
hdl/lcd_bus_writer.sv
hdl/lcd_frame_sequencer.sv
hdl/text_buffer.sv
hdl/lcd_display_top.sv
test/lcd_display_tb.sv
